//--- design/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    localparam int tag_w = 4;

    // architectural widths
    localparam int reg_w = 5;
    localparam int xlen = 32;

    // state of one slot, 74 bits
    typedef struct packed {
        logic             valid;
        logic             done;
        logic             pred_taken;
        // resolved branch direction from the execution unit
        logic             act_taken;
        logic             is_store;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  data;
        // branch target, used as redirect PC on a mispredict
        logic [xlen-1:0]  target;
    } entry_t;

endpackage

`default_nettype wire

//--- design/alloc_if.sv
`timescale 1ns/1ns
`default_nettype none

// one allocation write, allocator to entries
interface alloc_if;

    logic                      en;
    logic [rob_pkg::tag_w-1:0] tag;
    logic [rob_pkg::reg_w-1:0] rd;
    logic                      pred_taken;
    logic                      is_store;

    modport src (
        output en, tag, rd, pred_taken, is_store
    );

    modport sink (
        input en, tag, rd, pred_taken, is_store
    );

endinterface

`default_nettype wire

//--- design/wb_if.sv
`timescale 1ns/1ns
`default_nettype none

// one execution result, no back-pressure
interface wb_if;

    logic                      en;
    logic [rob_pkg::tag_w-1:0] tag;
    logic [rob_pkg::xlen-1:0]  data;
    logic                      taken;
    logic [rob_pkg::xlen-1:0]  target;

    modport src (output en, tag, data, taken, target);

    modport sink (input en, tag, data, taken, target);

endinterface

`default_nettype wire

//--- design/rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module rob_alloc (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      alloc_req,
    input  wire logic [rob_pkg::reg_w-1:0] alloc_rd,
    input  wire logic                      alloc_pred_taken,
    input  wire logic                      alloc_is_store,
    input  wire logic                      retire_any,
    input  wire logic                      flush,
    output logic                           alloc_gnt,
    output logic [rob_pkg::tag_w-1:0]      alloc_tag,
    alloc_if.src                           alloc
);

    logic [rob_pkg::tag_w-1:0] tail;
    // one bit wider than a tag so 16 fits
    logic [rob_pkg::tag_w:0]   count;
    logic                      full;

    assign full      = (count == (rob_pkg::tag_w + 1)'(rob_pkg::rob_depth));
    assign alloc_gnt = alloc_req && !full && !flush;
    assign alloc_tag = tail;

    assign alloc.en         = alloc_gnt;
    assign alloc.tag        = tail;
    assign alloc.rd         = alloc_rd;
    assign alloc.pred_taken = alloc_pred_taken;
    assign alloc.is_store   = alloc_is_store;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            // tail wraps at depth since depth is a power of two
            if (alloc_gnt) begin
                tail <= tail + 1'b1;
            end
            case ({alloc_gnt, retire_any})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // filling the last free slot blocks the next grant
    no_gnt_when_full: assert property (@(posedge clk) disable iff (rst)
        alloc_gnt && !retire_any
            && count == (rob_pkg::tag_w + 1)'(rob_pkg::rob_depth - 1)
        |=> !alloc_gnt);

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= (rob_pkg::tag_w + 1)'(rob_pkg::rob_depth));

endmodule

`default_nettype wire

//--- design/rob_entry.sv
`timescale 1ns/1ns
`default_nettype none

module rob_entry #(
    parameter logic [rob_pkg::tag_w-1:0] entry_idx = '0
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       retire,
    input  wire logic       flush,
    alloc_if.sink           alloc,
    wb_if.sink              wb,
    output rob_pkg::entry_t status
);

    logic alloc_hit;
    logic wb_hit;

    assign alloc_hit = alloc.en && (alloc.tag == entry_idx);
    assign wb_hit    = wb.en && (wb.tag == entry_idx);

    // control bits
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            status.valid <= 1'b0;
            status.done  <= 1'b0;
        end else if (retire) begin
            status.valid <= 1'b0;
            status.done  <= 1'b0;
        end else begin
            if (alloc_hit) begin
                status.valid <= 1'b1;
                status.done  <= 1'b0;
            end
            if (wb_hit) begin
                status.done <= 1'b1;
            end
        end
    end

    // payload, only meaningful while valid
    always_ff @(posedge clk) begin
        if (alloc_hit) begin
            status.pred_taken <= alloc.pred_taken;
            status.is_store   <= alloc.is_store;
            status.rd         <= alloc.rd;
        end
        if (wb_hit) begin
            status.data      <= wb.data;
            status.act_taken <= wb.taken;
            status.target    <= wb.target;
        end
    end

    // execution may only report tags still in flight
    wb_only_in_flight: assert property (@(posedge clk) disable iff (rst)
        wb_hit |-> status.valid);

    // allocator must never overrun the head
    alloc_only_free: assert property (@(posedge clk) disable iff (rst)
        alloc_hit |-> !status.valid);

endmodule

`default_nettype wire

//--- design/rob_commit.sv
`timescale 1ns/1ns
`default_nettype none

module rob_commit (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire rob_pkg::entry_t              status [rob_pkg::rob_depth],
    output logic [rob_pkg::rob_depth-1:0]     retire,
    output logic                              retire_any,
    output logic                              rf_we,
    output logic [rob_pkg::reg_w-1:0]         rf_rd,
    output logic [rob_pkg::xlen-1:0]          rf_data,
    output logic [rob_pkg::tag_w-1:0]         rf_tag,
    output logic                              store_en,
    output logic [rob_pkg::tag_w-1:0]         store_tag,
    output logic                              flush,
    output logic [rob_pkg::xlen-1:0]          redirect_pc
);

    logic [rob_pkg::tag_w-1:0] head;
    rob_pkg::entry_t           head_st;
    logic                      fire;
    logic                      mispredict;

    assign head_st = status[head];

    // no retire during the flush pulse since younger entries are dead
    assign fire       = head_st.valid && head_st.done && !flush;
    assign mispredict = !head_st.is_store && (head_st.pred_taken != head_st.act_taken);

    assign retire_any = fire;
    assign retire     = fire ? ({{(rob_pkg::rob_depth - 1){1'b0}}, 1'b1} << head) : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
        end else if (fire) begin
            head <= head + 1'b1;
        end
    end

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we    <= 1'b0;
            store_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            rf_we    <= fire && !head_st.is_store;
            store_en <= fire && head_st.is_store;
            flush    <= fire && mispredict;
        end
    end

    // values that go with the strobes
    always_ff @(posedge clk) begin
        if (fire) begin
            rf_rd       <= head_st.rd;
            rf_data     <= head_st.data;
            rf_tag      <= head;
            store_tag   <= head;
            redirect_pc <= head_st.target;
        end
    end

    retire_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(retire));

    // a flush leaves the slot at the head empty
    head_empty_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !head_st.valid);

endmodule

`default_nettype wire

//--- design/rob_top.sv
`timescale 1ns/1ns
`default_nettype none

module rob_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      alloc_req,
    input  wire logic [rob_pkg::reg_w-1:0] alloc_rd,
    input  wire logic                      alloc_pred_taken,
    input  wire logic                      alloc_is_store,
    input  wire logic                      wb_en,
    input  wire logic [rob_pkg::tag_w-1:0] wb_tag,
    input  wire logic [rob_pkg::xlen-1:0]  wb_data,
    input  wire logic                      wb_taken,
    input  wire logic [rob_pkg::xlen-1:0]  wb_target,
    output logic                           alloc_gnt,
    output logic [rob_pkg::tag_w-1:0]      alloc_tag,
    output logic                           rf_we,
    output logic [rob_pkg::reg_w-1:0]      rf_rd,
    output logic [rob_pkg::xlen-1:0]       rf_data,
    output logic [rob_pkg::tag_w-1:0]      rf_tag,
    output logic                           store_en,
    output logic [rob_pkg::tag_w-1:0]      store_tag,
    output logic                           flush,
    output logic [rob_pkg::xlen-1:0]       redirect_pc
);

    alloc_if alloc_bus ();
    wb_if    wb_bus ();

    rob_pkg::entry_t                   status [rob_pkg::rob_depth];
    logic [rob_pkg::rob_depth-1:0]     retire;
    logic                              retire_any;

    // execution side writeback
    assign wb_bus.en     = wb_en;
    assign wb_bus.tag    = wb_tag;
    assign wb_bus.data   = wb_data;
    assign wb_bus.taken  = wb_taken;
    assign wb_bus.target = wb_target;

    rob_alloc rob_alloc_i (
        .clk              (clk),
        .rst              (rst),
        .alloc_req        (alloc_req),
        .alloc_rd         (alloc_rd),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_is_store   (alloc_is_store),
        .retire_any       (retire_any),
        .flush            (flush),
        .alloc_gnt        (alloc_gnt),
        .alloc_tag        (alloc_tag),
        .alloc            (alloc_bus.src)
    );

    for (genvar i = 0; i < rob_pkg::rob_depth; i++) begin : g_entry
        rob_entry #(
            .entry_idx ((rob_pkg::tag_w)'(i))
        ) rob_entry_i (
            .clk    (clk),
            .rst    (rst),
            .retire (retire[i]),
            .flush  (flush),
            .alloc  (alloc_bus.sink),
            .wb     (wb_bus.sink),
            .status (status[i])
        );
    end

    rob_commit rob_commit_i (
        .clk         (clk),
        .rst         (rst),
        .status      (status),
        .retire      (retire),
        .retire_any  (retire_any),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .rf_tag      (rf_tag),
        .store_en    (store_en),
        .store_tag   (store_tag),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

//--- dv/rob_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rob_tb;

    localparam int wait_limit = 100;

    logic                      clk;
    logic                      rst;
    logic                      alloc_req;
    logic [rob_pkg::reg_w-1:0] alloc_rd;
    logic                      alloc_pred_taken;
    logic                      alloc_is_store;
    logic                      wb_en;
    logic [rob_pkg::tag_w-1:0] wb_tag;
    logic [rob_pkg::xlen-1:0]  wb_data;
    logic                      wb_taken;
    logic [rob_pkg::xlen-1:0]  wb_target;
    logic                      alloc_gnt;
    logic [rob_pkg::tag_w-1:0] alloc_tag;
    logic                      rf_we;
    logic [rob_pkg::reg_w-1:0] rf_rd;
    logic [rob_pkg::xlen-1:0]  rf_data;
    logic [rob_pkg::tag_w-1:0] rf_tag;
    logic                      store_en;
    logic [rob_pkg::tag_w-1:0] store_tag;
    logic                      flush;
    logic [rob_pkg::xlen-1:0]  redirect_pc;

    int          seed;
    int          rf_tag_q[$];
    int          rf_rd_q[$];
    logic [31:0] rf_data_q[$];
    int          st_tag_q[$];
    logic [31:0] fl_pc_q[$];

    rob_top rob_top_i (
        .clk (clk), .rst (rst),
        .alloc_req (alloc_req), .alloc_rd (alloc_rd),
        .alloc_pred_taken (alloc_pred_taken), .alloc_is_store (alloc_is_store),
        .wb_en (wb_en), .wb_tag (wb_tag), .wb_data (wb_data),
        .wb_taken (wb_taken), .wb_target (wb_target),
        .alloc_gnt (alloc_gnt), .alloc_tag (alloc_tag),
        .rf_we (rf_we), .rf_rd (rf_rd), .rf_data (rf_data), .rf_tag (rf_tag),
        .store_en (store_en), .store_tag (store_tag),
        .flush (flush), .redirect_pc (redirect_pc)
    );

    always #20 clk = ~clk;

    // record commit side pulses once the registered outputs settle
    always @(posedge clk) begin
        #1;
        if (rf_we) begin
            rf_tag_q.push_back(int'(rf_tag));
            rf_rd_q.push_back(int'(rf_rd));
            rf_data_q.push_back(rf_data);
        end
        if (store_en) begin
            st_tag_q.push_back(int'(store_tag));
        end
        if (flush) begin
            fl_pc_q.push_back(redirect_pc);
        end
    end

    // result value an execution unit reports for a tag
    function automatic logic [31:0] wb_value(input int tag);
        return 32'h5eed_0000 + tag * 32'h0000_0101;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Checks failed");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        alloc_req = 1'b0;
        wb_en = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        rf_tag_q.delete();
        rf_rd_q.delete();
        rf_data_q.delete();
        st_tag_q.delete();
        fl_pc_q.delete();
    endtask

    // holds the request until granted and returns the tag
    task automatic do_alloc(input logic [rob_pkg::reg_w-1:0] rd, input logic pred,
                            input logic st, output logic [rob_pkg::tag_w-1:0] tag);
        int n;
        n = 0;
        alloc_req = 1'b1;
        alloc_rd = rd;
        alloc_pred_taken = pred;
        alloc_is_store = st;
        #1;
        while (!alloc_gnt) begin
            @(posedge clk);
            #3;
            n++;
            if (n > wait_limit) give_up("a grant on the allocation port");
        end
        tag = alloc_tag;
        @(posedge clk);
        #2;
        alloc_req = 1'b0;
    endtask

    task automatic do_wb(input logic [rob_pkg::tag_w-1:0] tag, input logic [31:0] data,
                         input logic taken, input logic [31:0] target);
        wb_en = 1'b1;
        wb_tag = tag;
        wb_data = data;
        wb_taken = taken;
        wb_target = target;
        @(posedge clk);
        #2;
        wb_en = 1'b0;
    endtask

    task automatic wait_events(input string what, input int rf_n, input int st_n,
                               input int fl_n);
        int n;
        n = 0;
        while (rf_tag_q.size() < rf_n || st_tag_q.size() < st_n || fl_pc_q.size() < fl_n) begin
            @(posedge clk);
            #2;
            n++;
            if (n > wait_limit) give_up(what);
        end
    endtask

    task automatic test_reset_and_order();
        logic [rob_pkg::tag_w-1:0] tag;
        apply_reset();
        check_eq("rf_we", 32'(rf_we), 0);
        check_eq("store_en", 32'(store_en), 0);
        check_eq("flush", 32'(flush), 0);
        for (int i = 0; i < 4; i++) begin
            do_alloc(5'(i + 1), 1'b0, 1'b0, tag);
            check_eq("alloc_tag", 32'(tag), i);
        end
    endtask

    task automatic test_in_order_commit();
        logic [rob_pkg::tag_w-1:0] tag;
        int order[8];
        int j;
        int tmp;
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            do_alloc(5'(3 + 3 * i), 1'b0, 1'b0, tag);
            check_eq("alloc_tag", 32'(tag), i);
            order[i] = i;
        end
        for (int i = 7; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            do_wb(4'(order[i]), wb_value(order[i]), 1'b0, 32'h0);
        end
        wait_events("eight register writes", 8, 0, 0);
        for (int i = 0; i < 8; i++) begin
            check_eq("rf_tag", rf_tag_q[i], i);
            check_eq("rf_rd", rf_rd_q[i], 3 + 3 * i);
            check_eq("rf_data", rf_data_q[i], wb_value(i));
        end
    endtask

    task automatic test_full();
        logic [rob_pkg::tag_w-1:0] tag;
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            do_alloc(5'(i), 1'b0, 1'b0, tag);
            check_eq("alloc_tag", 32'(tag), i);
        end
        alloc_req = 1'b1;
        repeat (4) begin
            #1;
            check_eq("alloc_gnt", 32'(alloc_gnt), 0);
            @(posedge clk);
            #2;
        end
        do_wb(4'd0, wb_value(0), 1'b0, 32'h0);
        do_alloc(5'd20, 1'b0, 1'b0, tag);
        check_eq("alloc_tag", 32'(tag), 0);
        wait_events("the head to retire", 1, 0, 0);
        check_eq("rf_tag", rf_tag_q[0], 0);
    endtask

    task automatic test_store();
        logic [rob_pkg::tag_w-1:0] st_tag;
        logic [rob_pkg::tag_w-1:0] op_tag;
        apply_reset();
        do_alloc(5'd9, 1'b0, 1'b1, st_tag);
        do_alloc(5'd10, 1'b0, 1'b0, op_tag);
        do_wb(op_tag, wb_value(1), 1'b0, 32'h0);
        do_wb(st_tag, wb_value(0), 1'b0, 32'h0);
        wait_events("a store release and a register write", 1, 1, 0);
        check_eq("store_tag", st_tag_q[0], 0);
        check_eq("rf_we count", rf_tag_q.size(), 1);
        check_eq("rf_tag", rf_tag_q[0], 1);
        check_eq("rf_rd", rf_rd_q[0], 10);
    endtask

    task automatic test_mispredict();
        logic [rob_pkg::tag_w-1:0] tag;
        apply_reset();
        do_alloc(5'd7, 1'b0, 1'b0, tag);
        for (int i = 1; i < 4; i++) begin
            do_alloc(5'(11 + i), 1'b0, 1'b0, tag);
        end
        for (int i = 1; i < 4; i++) begin
            do_wb(4'(i), wb_value(i), 1'b0, 32'h0);
        end
        // branch resolves taken against a not-taken prediction
        do_wb(4'd0, wb_value(0), 1'b1, 32'h0000_8a40);
        wait_events("the mispredict flush", 1, 0, 1);
        repeat (6) @(posedge clk);
        #2;
        check_eq("rf_we count", rf_tag_q.size(), 1);
        check_eq("rf_tag", rf_tag_q[0], 0);
        check_eq("rf_rd", rf_rd_q[0], 7);
        check_eq("flush count", fl_pc_q.size(), 1);
        check_eq("redirect_pc", fl_pc_q[0], 32'h0000_8a40);
        do_alloc(5'd1, 1'b0, 1'b0, tag);
        check_eq("alloc_tag", 32'(tag), 0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'hdde;
        alloc_req = 1'b0;
        alloc_rd = '0;
        alloc_pred_taken = 1'b0;
        alloc_is_store = 1'b0;
        wb_en = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        wb_taken = 1'b0;
        wb_target = '0;
        test_reset_and_order();
        test_in_order_commit();
        test_full();
        test_store();
        test_mispredict();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/rob_pkg.sv
design/alloc_if.sv
design/wb_if.sv
design/rob_alloc.sv
design/rob_entry.sv
design/rob_commit.sv
design/rob_top.sv
dv/rob_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rob_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
